//--- dual_issue_front.f
dual_issue_pkg.sv
instr_classifier.sv
issue_queue.sv
pair_selector.sv
dual_issue_front.sv
dual_issue_front_tb.sv

//--- dual_issue_front.sv
module dual_issue_front (
  input logic clock,
  input logic reset,
  input dual_issue_pkg::fetch_t fetch,
  output dual_issue_pkg::issue_t issue,
  output logic stall
);
  import dual_issue_pkg::*;

  slot_t head0;
  slot_t head1;
  usage_t usage0;
  usage_t usage1;
  logic [1:0] pass;

  issue_queue queue (
    .clock (clock),
    .reset (reset),
    .fetch (fetch),
    .pass  (pass),
    .head0 (head0),
    .head1 (head1),
    .stall (stall)
  );

  // One decoder per head slot
  instr_classifier classify0 (
    .slot  (head0),
    .usage (usage0)
  );

  instr_classifier classify1 (
    .slot  (head1),
    .usage (usage1)
  );

  pair_selector selector (
    .clock  (clock),
    .head0  (head0),
    .head1  (head1),
    .usage0 (usage0),
    .usage1 (usage1),
    .pass   (pass),
    .issue  (issue)
  );

endmodule

//--- dual_issue_front_tb.sv
module dual_issue_front_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import dual_issue_pkg::*;

  localparam int reset_cycles = 10;
  localparam int directed_cycles = 200;
  localparam int random_pairs = 100;
  localparam int max_cycles = reset_cycles + directed_cycles + random_pairs * 6;

  logic clock;
  logic reset;
  fetch_t fetch;
  issue_t issue;
  logic stall;

  int errors = 0;
  int checks = 0;
  logic last_stall = 1'b0;
  logic [31:0] next_pc = 32'h0000_1000;
  logic [31:0] lcg_state = 32'hd40a_83c4;

  // Expected queue contents, oldest first
  logic [31:0] model_pc[$];
  logic [31:0] model_instr[$];

  dual_issue_front uut (
    .clock (clock),
    .reset (reset),
    .fetch (fetch),
    .issue (issue),
    .stall (stall)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Encoding and classification of the reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic is_basic(input logic [31:0] ins);
    return ins[6:0] inside {opcode_lui, opcode_auipc, opcode_immediate, opcode_register};
  endfunction

  function automatic logic writes_int(input logic [31:0] ins);
    logic [6:0] op;
    logic rd_used;
    op = ins[6:0];
    rd_used = ins[11:7] != 5'd0;
    if (op inside {opcode_lui, opcode_auipc, opcode_immediate, opcode_register,
                   opcode_jal, opcode_jalr, opcode_load}) begin
      return rd_used;
    end
    if (op == opcode_system) begin
      return rd_used && ins[14:12] != 3'd0 && ins[14:12] != 3'd4;
    end
    // These fp forms write the integer file even for x0
    return op == opcode_fp && ins[31:27] inside {funct_fcomp, funct_fmv_f2i, funct_fconv_f2i};
  endfunction

  function automatic logic reads_int(input logic [31:0] ins, input logic [4:0] r);
    if (ins[6:0] == opcode_immediate) begin
      return ins[19:15] == r;
    end
    return ins[6:0] == opcode_register && (ins[19:15] == r || ins[24:20] == r);
  endfunction

  // Basic instructions read no fp registers, so an fp hazard only arises
  // where pairing is already refused
  function automatic logic [1:0] model_pass();
    if (model_pc.size() == 0) begin
      return 2'd0;
    end
    if (model_pc.size() == 1) begin
      return 2'd1;
    end
    if (!is_basic(model_instr[1])) begin
      return 2'd1;
    end
    if (writes_int(model_instr[0]) && reads_int(model_instr[1], model_instr[0][11:7])) begin
      return 2'd1;
    end
    return 2'd2;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    r = lcg_next();
    // Few registers, so that dependences are common
    rd = {2'b00, r[27:25]};
    rs1 = {2'b00, r[24:22]};
    rs2 = {2'b00, r[21:19]};
    case (r[31:28])
      4'd0, 4'd1: return r_type(7'd0, rs2, rs1, 3'd0, rd, opcode_register);
      4'd2: return r_type(7'h20, rs2, rs1, 3'd0, rd, opcode_register);
      4'd5: return i_type(r[11:0], r[18:14], 3'd0, rd, opcode_lui);
      4'd6: return i_type(r[11:0], r[18:14], 3'd0, rd, opcode_auipc);
      4'd7: return i_type(12'd8, rs1, 3'd2, rd, opcode_load);
      4'd8: return r_type(7'd0, rs2, rs1, 3'd2, 5'd4, opcode_store);
      4'd9: return r_type(7'd0, rs2, rs1, 3'd0, 5'd8, opcode_branch);
      4'd10: return r_type({funct_fadd, 2'b00}, rs2, rs1, 3'd0, rd, opcode_fp);
      4'd11: return r_type({r[18:14], 2'b00}, rs2, rs1, 3'd0, rd, opcode_fmadd);
      4'd12: return r_type({funct_fmv_f2i, 2'b00}, 5'd0, rs1, 3'd0, rd, opcode_fp);
      4'd13: return r_type(7'd0, rs2, rs1, 3'd0, rd, 7'b1111111);
      default: return i_type(r[11:0], rs1, 3'd0, rd, opcode_immediate);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and cycle driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_issue(input string name, input issue_t expected, input issue_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s issue: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_stall(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s stall: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // One clock cycle: drive, let the combinational path settle, compare, retire
  task automatic step(input string name, input logic valid, input logic [31:0] pc,
                      input logic [63:0] rdata);
    issue_t expected;
    logic [1:0] n;
    @(posedge clock);
    #2;
    fetch.valid = valid;
    fetch.pc = pc;
    fetch.rdata = rdata;
    if (valid) begin
      model_pc.push_back(pc);
      model_instr.push_back(rdata[31:0]);
      model_pc.push_back(pc + 32'd4);
      model_instr.push_back(rdata[63:32]);
    end
    #15;
    n = model_pass();
    expected = '{pc0: 32'd0, instr0: nop_instr, pc1: 32'd0, instr1: nop_instr};
    if (n >= 2'd1) begin
      expected.pc0 = model_pc[0];
      expected.instr0 = model_instr[0];
    end
    if (n == 2'd2) begin
      expected.pc1 = model_pc[1];
      expected.instr1 = model_instr[1];
    end
    check_issue(name, expected, issue);
    check_stall(name, model_pc.size() > stall_threshold, stall);
    last_stall = stall;
    repeat (n) begin
      void'(model_pc.pop_front());
      void'(model_instr.pop_front());
    end
  endtask

  task automatic fetch_pair(input string name, input logic [31:0] lo, input logic [31:0] hi);
    step(name, 1'b1, next_pc, {hi, lo});
    next_pc = next_pc + 32'd8;
  endtask

  task automatic drain(input string name);
    while (model_pc.size() > 0) begin
      step(name, 1'b0, 32'd0, 64'd0);
    end
    step(name, 1'b0, 32'd0, 64'd0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    repeat (3) step("reset_state", 1'b0, 32'd0, 64'd0);
  endtask

  task automatic independent_pairs();
    fetch_pair("independent_pair", r_type(7'd0, 5'd3, 5'd2, 3'd0, 5'd1, opcode_register),
               i_type(12'd1, 5'd5, 3'd0, 5'd4, opcode_immediate));
    fetch_pair("x0_pair", r_type(7'd0, 5'd2, 5'd1, 3'd0, 5'd0, opcode_register),
               i_type(12'd5, 5'd0, 3'd0, 5'd3, opcode_immediate));
    drain("independent_pair");
  endtask

  task automatic dependences();
    fetch_pair("int_dependence", r_type(7'd0, 5'd2, 5'd1, 3'd0, 5'd5, opcode_register),
               r_type(7'h20, 5'd7, 5'd5, 3'd0, 5'd6, opcode_register));
    drain("int_dependence");
    fetch_pair("fp_dependence", r_type({funct_fadd, 2'b00}, 5'd2, 5'd1, 3'd0, 5'd3, opcode_fp),
               r_type({5'd3, 2'b00}, 5'd2, 5'd1, 3'd0, 5'd4, opcode_fmadd));
    drain("fp_dependence");
  endtask

  task automatic class_ordering();
    logic [31:0] basic;
    logic [31:0] complex;
    basic = i_type(12'd7, 5'd9, 3'd0, 5'd10, opcode_immediate);
    complex = i_type(12'd0, 5'd11, 3'd2, 5'd12, opcode_load);
    fetch_pair("complex_basic", complex, basic);
    drain("complex_basic");
    fetch_pair("basic_complex", basic, complex);
    drain("basic_complex");
    fetch_pair("complex_complex", complex, r_type(7'd0, 5'd1, 5'd2, 3'd2, 5'd4, opcode_store));
    drain("complex_complex");
    fetch_pair("unknown_opcode", basic, r_type(7'd0, 5'd1, 5'd2, 3'd0, 5'd3, 7'b1111111));
    drain("unknown_opcode");
  endtask

  task automatic back_pressure();
    repeat (16) begin
      if (last_stall) begin
        step("back_pressure", 1'b0, 32'd0, 64'd0);
      end else begin
        fetch_pair("back_pressure", i_type(12'd0, 5'd1, 3'd2, 5'd2, opcode_load),
                   i_type(12'd4, 5'd1, 3'd2, 5'd3, opcode_load));
      end
    end
    drain("back_pressure");
  endtask

  task automatic random_stream();
    int pairs;
    logic [31:0] gap;
    logic [31:0] lo;
    logic [31:0] hi;
    pairs = 0;
    while (pairs < random_pairs) begin
      gap = lcg_next();
      if (!last_stall && gap[31:30] != 2'b00) begin
        lo = random_instr();
        hi = random_instr();
        fetch_pair("random_stream", lo, hi);
        pairs++;
      end else begin
        step("random_stream", 1'b0, 32'd0, 64'd0);
      end
    end
    drain("random_stream");
  endtask

  initial begin
    reset = 1'b0;
    fetch = '0;
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset = 1'b1;
    reset_state();
    independent_pairs();
    dependences();
    class_ordering();
    back_pressure();
    random_stream();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(max_cycles * 20 + 1000);
    $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- dual_issue_pkg.sv
package dual_issue_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Queue sizing
  ////////////////////////////////////////////////////////////////////////////

  localparam int queue_depth = 8;
  localparam int queue_index_w = 3;
  localparam int stall_threshold = 4;

  // addi x0, x0, 0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register = 7'b0110011;
  localparam logic [6:0] opcode_system = 7'b1110011;
  localparam logic [6:0] opcode_fload = 7'b0000111;
  localparam logic [6:0] opcode_fstore = 7'b0100111;
  localparam logic [6:0] opcode_fp = 7'b1010011;
  localparam logic [6:0] opcode_fmadd = 7'b1000011;
  localparam logic [6:0] opcode_fmsub = 7'b1000111;
  localparam logic [6:0] opcode_fnmsub = 7'b1001011;
  localparam logic [6:0] opcode_fnmadd = 7'b1001111;

  // funct5 field of the fp opcode
  localparam logic [4:0] funct_fadd = 5'b00000;
  localparam logic [4:0] funct_fsub = 5'b00001;
  localparam logic [4:0] funct_fmul = 5'b00010;
  localparam logic [4:0] funct_fdiv = 5'b00011;
  localparam logic [4:0] funct_fsqrt = 5'b01011;
  localparam logic [4:0] funct_fsgnj = 5'b00100;
  localparam logic [4:0] funct_fminmax = 5'b00101;
  localparam logic [4:0] funct_fcomp = 5'b10100;
  localparam logic [4:0] funct_fmv_f2i = 5'b11100;
  localparam logic [4:0] funct_fmv_i2f = 5'b11110;
  localparam logic [4:0] funct_fconv_f2i = 5'b11000;
  localparam logic [4:0] funct_fconv_i2f = 5'b11010;

  ////////////////////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////////////////////

  // Low half of rdata is the instruction at pc, high half at pc+4
  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [63:0] rdata;
  } fetch_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } slot_t;

  typedef struct packed {
    logic basic;
    logic complex;
    logic wren;
    logic rden1;
    logic rden2;
    logic fwren;
    logic frden1;
    logic frden2;
    logic frden3;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [4:0] raddr3;
  } usage_t;

  typedef struct packed {
    logic [31:0] pc0;
    logic [31:0] instr0;
    logic [31:0] pc1;
    logic [31:0] instr1;
  } issue_t;

endpackage

//--- instr_classifier.sv
module instr_classifier (
  input dual_issue_pkg::slot_t slot,
  output dual_issue_pkg::usage_t usage
);
  import dual_issue_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rs3;
  logic rd_nonzero;

  assign opcode = slot.instr[6:0];
  assign funct3 = slot.instr[14:12];
  assign funct5 = slot.instr[31:27];
  assign rd = slot.instr[11:7];
  assign rs1 = slot.instr[19:15];
  assign rs2 = slot.instr[24:20];
  assign rs3 = slot.instr[31:27];

  // Writes to x0 are dropped and never form a dependence
  assign rd_nonzero = |rd;

  always_comb begin
    usage = '0;
    usage.waddr = rd;
    usage.raddr1 = rs1;
    usage.raddr2 = rs2;
    usage.raddr3 = rs3;

    if (slot.valid) begin
      case (opcode)
        opcode_lui, opcode_auipc: begin
          usage.basic = 1'b1;
          usage.wren = rd_nonzero;
        end
        opcode_immediate: begin
          usage.basic = 1'b1;
          usage.wren = rd_nonzero;
          usage.rden1 = 1'b1;
        end
        opcode_register: begin
          usage.basic = 1'b1;
          usage.wren = rd_nonzero;
          usage.rden1 = 1'b1;
          usage.rden2 = 1'b1;
        end
        opcode_jal: begin
          usage.complex = 1'b1;
          usage.wren = rd_nonzero;
        end
        opcode_jalr, opcode_load: begin
          usage.complex = 1'b1;
          usage.wren = rd_nonzero;
          usage.rden1 = 1'b1;
        end
        opcode_branch, opcode_store: begin
          usage.complex = 1'b1;
          usage.rden1 = 1'b1;
          usage.rden2 = 1'b1;
        end
        opcode_system: begin
          usage.complex = 1'b1;
          case (funct3)
            // csrrw, csrrs, csrrc
            3'd1, 3'd2, 3'd3: begin
              usage.wren = rd_nonzero;
              usage.rden1 = 1'b1;
            end
            // Immediate csr forms
            3'd5, 3'd6, 3'd7: begin
              usage.wren = rd_nonzero;
            end
            default: begin
            end
          endcase
        end
        opcode_fload: begin
          usage.complex = 1'b1;
          usage.rden1 = 1'b1;
          usage.fwren = 1'b1;
        end
        opcode_fstore: begin
          usage.complex = 1'b1;
          usage.rden1 = 1'b1;
          usage.frden1 = 1'b1;
        end
        opcode_fp: begin
          usage.complex = 1'b1;
          case (funct5)
            funct_fadd, funct_fsub, funct_fmul, funct_fdiv,
            funct_fsgnj, funct_fminmax: begin
              usage.fwren = 1'b1;
              usage.frden1 = 1'b1;
              usage.frden2 = 1'b1;
            end
            funct_fsqrt: begin
              usage.fwren = 1'b1;
              usage.frden1 = 1'b1;
            end
            // Results land in the integer file, x0 included
            funct_fcomp: begin
              usage.wren = 1'b1;
              usage.frden1 = 1'b1;
              usage.frden2 = 1'b1;
            end
            funct_fmv_f2i, funct_fconv_f2i: begin
              usage.wren = 1'b1;
              usage.frden1 = 1'b1;
            end
            funct_fmv_i2f, funct_fconv_i2f: begin
              usage.rden1 = 1'b1;
              usage.fwren = 1'b1;
            end
            default: begin
            end
          endcase
        end
        opcode_fmadd, opcode_fmsub, opcode_fnmsub, opcode_fnmadd: begin
          usage.complex = 1'b1;
          usage.fwren = 1'b1;
          usage.frden1 = 1'b1;
          usage.frden2 = 1'b1;
          usage.frden3 = 1'b1;
        end
        // Unknown opcode issues alone and reads nothing
        default: begin
          usage.complex = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- issue_queue.sv
module issue_queue (
  input logic clock,
  input logic reset,
  input dual_issue_pkg::fetch_t fetch,
  input logic [1:0] pass,
  output dual_issue_pkg::slot_t head0,
  output dual_issue_pkg::slot_t head1,
  output logic stall
);
  import dual_issue_pkg::*;

  logic [31:0] pc_mem [queue_depth];
  logic [31:0] instr_mem [queue_depth];

  logic [queue_index_w:0] count;
  logic [queue_index_w:0] count_push;
  logic [queue_index_w-1:0] wid;
  logic [queue_index_w-1:0] wid_second;
  logic [queue_index_w-1:0] rid;
  logic [queue_index_w-1:0] rid_second;

  assign wid_second = wid + 1'b1;
  assign rid_second = rid + 1'b1;

  // Occupancy as seen by the issue logic this cycle
  assign count_push = fetch.valid ? count + 2'd2 : count;

  assign stall = count_push > stall_threshold;

  ////////////////////////////////////////////////////////////////////////////
  // Head slots, with bypass from a fetch arriving this cycle
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    head0 = '{valid: 1'b0, pc: 32'd0, instr: nop_instr};
    head1 = '{valid: 1'b0, pc: 32'd0, instr: nop_instr};

    if (count_push >= 1) begin
      head0.valid = 1'b1;
      if (count >= 1) begin
        head0.pc = pc_mem[rid];
        head0.instr = instr_mem[rid];
      end else begin
        head0.pc = fetch.pc;
        head0.instr = fetch.rdata[31:0];
      end
    end

    if (count_push >= 2) begin
      head1.valid = 1'b1;
      if (count >= 2) begin
        head1.pc = pc_mem[rid_second];
        head1.instr = instr_mem[rid_second];
      end else if (count == 1) begin
        head1.pc = fetch.pc;
        head1.instr = fetch.rdata[31:0];
      end else begin
        head1.pc = fetch.pc + 32'd4;
        head1.instr = fetch.rdata[63:32];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (fetch.valid) begin
      pc_mem[wid] <= fetch.pc;
      instr_mem[wid] <= fetch.rdata[31:0];
      pc_mem[wid_second] <= fetch.pc + 32'd4;
      instr_mem[wid_second] <= fetch.rdata[63:32];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      wid <= '0;
      rid <= '0;
    end else begin
      count <= count_push - {2'b00, pass};
      if (fetch.valid) begin
        wid <= wid + 2'd2;
      end
      rid <= rid + {1'b0, pass};
    end
  end

  // Holds only while the fetcher honours stall
  assert property (@(posedge clock) disable iff (!reset) count <= queue_depth);

  // Selector may only retire slots that the queue actually presented
  assert property (@(posedge clock) disable iff (!reset)
    pass <= {1'b0, head0.valid} + {1'b0, head1.valid});

endmodule

//--- pair_selector.sv
module pair_selector (
  input logic clock,
  input dual_issue_pkg::slot_t head0,
  input dual_issue_pkg::slot_t head1,
  input dual_issue_pkg::usage_t usage0,
  input dual_issue_pkg::usage_t usage1,
  output logic [1:0] pass,
  output dual_issue_pkg::issue_t issue
);
  import dual_issue_pkg::*;

  logic pairable;
  logic int_hazard;
  logic fp_hazard;

  // Second slot must be basic, first may be either class
  assign pairable = (usage0.basic | usage0.complex) & usage1.basic;

  always_comb begin
    int_hazard = 1'b0;
    if (usage0.wren) begin
      if (usage1.rden1 && usage1.raddr1 == usage0.waddr) begin
        int_hazard = 1'b1;
      end
      if (usage1.rden2 && usage1.raddr2 == usage0.waddr) begin
        int_hazard = 1'b1;
      end
    end
  end

  always_comb begin
    fp_hazard = 1'b0;
    if (usage0.fwren) begin
      if (usage1.frden1 && usage1.raddr1 == usage0.waddr) begin
        fp_hazard = 1'b1;
      end
      if (usage1.frden2 && usage1.raddr2 == usage0.waddr) begin
        fp_hazard = 1'b1;
      end
      if (usage1.frden3 && usage1.raddr3 == usage0.waddr) begin
        fp_hazard = 1'b1;
      end
    end
  end

  always_comb begin
    if (!head0.valid) begin
      pass = 2'd0;
    end else if (!head1.valid) begin
      pass = 2'd1;
    end else if (pairable && !int_hazard && !fp_hazard) begin
      pass = 2'd2;
    end else begin
      pass = 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Issue slots, unused ones carry a nop
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    issue.pc0 = (pass > 0) ? head0.pc : 32'd0;
    issue.instr0 = (pass > 0) ? head0.instr : nop_instr;
    issue.pc1 = (pass > 1) ? head1.pc : 32'd0;
    issue.instr1 = (pass > 1) ? head1.instr : nop_instr;
  end

  // At most two slots exist, so three can never retire
  assert property (@(posedge clock) pass != 2'd3);

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal --top-module dual_issue_front_tb \
  -f dual_issue_front.f -o dual_issue_front_sim > build.log 2>&1 &&
./obj_dir/dual_issue_front_sim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 ||
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
